// File: Makefile
VERILATOR ?= verilator
TOP       ?= periph_tb
FILELIST  ?= periph.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert
FAIL_MSG  ?= CHECKS FAILED
PASS_MSG  ?= ALL CHECKS PASSED

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o $(TOP)

run: compile
	-./$(BUILD_DIR)/$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "Simulation reported failure"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "Simulation ended early"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: logic/byte_latch_periph.sv
// Byte latch on a byte slot; writes of any size use bits 7..0, write counter wraps at 256
`include "periph_defines.svh"

module byte_latch_periph
    import periph_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,
    input  periph_req_t i_req,
    input  logic        i_sel,
    output simple_rsp_t o_rsp
);

    localparam logic [3:0] LATCH_OFS = 4'h0;
    localparam logic [3:0] COUNT_OFS = 4'h1;

    logic [3:0] ofs;
    logic       wr_latch;
    pin_byte_t  latch_q;
    logic [7:0] count_q;
    pin_byte_t  rd_data;

    assign ofs      = i_req.addr[3:0];
    assign wr_latch = i_sel && (i_req.write_size != SIZE_IDLE) && (ofs == LATCH_OFS);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            latch_q <= '0;
            count_q <= '0;
        end else if (wr_latch) begin
            latch_q <= i_req.wdata[7:0];
            count_q <= count_q + 8'd1;
        end
    end

    always_comb begin
        unique case (ofs)
            LATCH_OFS: rd_data = latch_q;
            COUNT_OFS: rd_data = count_q;
            default:   rd_data = '0;
        endcase
    end

    assign o_rsp = '{data: rd_data, pins: latch_q};

endmodule

// File: logic/gpio_ctrl.sv
// GPIO on user slot 1; pins 0 and 1 start on the empty serial slot and drive 0 after reset
`include "periph_defines.svh"

module gpio_ctrl
    import periph_pkg::*;
(
    input  logic                                clk,
    input  logic                                rst_n,
    input  periph_req_t                         i_req,
    input  logic                                i_sel,
    input  pin_byte_t                           i_ui_in,
    input  pin_byte_t [`PERIPH_NUM_SLOTS-1:0]  i_user_pins,
    input  pin_byte_t [`PERIPH_NUM_SLOTS-1:0]  i_simple_pins,
    output user_rsp_t                           o_rsp,
    output pin_byte_t                           o_uo_out
);

    logic [5:0]      ofs;
    logic            wr_en;
    logic            sel_hit;
    logic [2:0]      sel_idx;
    pin_byte_t       out_q;
    func_sel_t [7:0] func_q;
    bus_word_t       rd_data;

    assign ofs   = i_req.addr[5:0];
    assign wr_en = i_sel && (i_req.write_size != SIZE_IDLE);

    // Function selects sit at 0x20, 0x24 .. 0x3c
    assign sel_hit = (ofs & 6'h23) == `GPIO_SEL_BASE;
    assign sel_idx = ofs[4:2];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            out_q <= '0;
        end else if (wr_en && ofs == `GPIO_OUT_OFS) begin
            out_q <= i_req.wdata[7:0];
        end
    end

    for (genvar p = 0; p < 8; p++) begin : g_pin
        always_ff @(posedge clk) begin
            if (!rst_n) begin
                if (p < 2) begin
                    func_q[p] <= func_sel_t'(`PERIPH_SERIAL_SLOT);
                end else begin
                    func_q[p] <= func_sel_t'(`PERIPH_GPIO_SLOT);
                end
            end else if (wr_en && sel_hit && sel_idx == 3'(p)) begin
                func_q[p] <= i_req.wdata[4:0];
            end
        end

        // Each pin takes its own bit from the chosen source byte
        always_comb begin
            if (func_q[p][4]) begin
                o_uo_out[p] = i_simple_pins[func_q[p][3:0]][p];
            end else begin
                o_uo_out[p] = i_user_pins[func_q[p][3:0]][p];
            end
        end
    end

    always_comb begin
        rd_data = '0;
        if (ofs == `GPIO_OUT_OFS) begin
            rd_data = bus_word_t'(out_q);
        end else if (ofs == `GPIO_IN_OFS) begin
            rd_data = bus_word_t'(i_ui_in);
        end else if (sel_hit) begin
            rd_data = bus_word_t'(func_q[sel_idx]);
        end
    end

    // GPIO never stalls the core
    assign o_rsp = '{data: rd_data, ready: 1'b1, pins: out_q};

endmodule

// File: logic/periph_decode.sv
// Purely combinational slot decode; byte slots always report ready and return zero-extended data
`include "periph_defines.svh"

module periph_decode
    import periph_pkg::*;
(
    input  periph_req_t                          i_req,
    input  user_rsp_t   [`PERIPH_NUM_SLOTS-1:0] i_user_rsp,
    input  simple_rsp_t [`PERIPH_NUM_SLOTS-1:0] i_simple_rsp,
    output slot_sel_t                            o_user_sel,
    output slot_sel_t                            o_simple_sel,
    output user_rsp_t                            o_rsp
);

    // User slots span 64 bytes, byte slots span 16 bytes
    logic [3:0] user_idx;
    logic [3:0] simple_idx;
    logic       is_simple;

    assign user_idx   = i_req.addr[9:6];
    assign simple_idx = i_req.addr[7:4];
    assign is_simple  = i_req.addr[`PERIPH_SIMPLE_BIT];

    always_comb begin
        o_user_sel   = '0;
        o_simple_sel = '0;

        if (is_simple) begin
            o_simple_sel[simple_idx] = 1'b1;
        end else begin
            o_user_sel[user_idx] = 1'b1;
        end
    end

    // Response mux toward the read buffer
    always_comb begin
        // Pins reach the GPIO block directly and are not muxed here
        o_rsp.pins = '0;
        if (is_simple) begin
            o_rsp.data  = bus_word_t'(i_simple_rsp[simple_idx].data);
            // Byte slots answer in the same cycle
            o_rsp.ready = 1'b1;
        end else begin
            o_rsp.data  = i_user_rsp[user_idx].data;
            o_rsp.ready = i_user_rsp[user_idx].ready;
        end
    end

endmodule

// File: logic/periph_defines.svh
// Address map constants for an 11-bit bus with 16 user slots and 16 byte slots; no slot 0 rule
`ifndef PERIPH_DEFINES_SVH
`define PERIPH_DEFINES_SVH

// Bus geometry
`define PERIPH_ADDR_W      11
`define PERIPH_DATA_W      32
`define PERIPH_NUM_SLOTS   16

// Address bit 10 selects the byte interface slots
`define PERIPH_SIMPLE_BIT  10

// Fixed user slot numbers
`define PERIPH_GPIO_SLOT   1
`define PERIPH_SERIAL_SLOT 2
`define PERIPH_WORD_SLOT_A 4
`define PERIPH_WORD_SLOT_B 5

// GPIO register offsets within its 64-byte window
`define GPIO_OUT_OFS       6'h00
`define GPIO_IN_OFS        6'h04
`define GPIO_SEL_BASE      6'h20

`endif

// File: logic/periph_pkg.sv
// Bus and slot types shared by the hub; size code 3 is idle, byte slots carry 8-bit data only
`include "periph_defines.svh"

package periph_pkg;

    typedef logic [`PERIPH_ADDR_W-1:0]    bus_addr_t;
    typedef logic [`PERIPH_DATA_W-1:0]    bus_word_t;
    typedef logic [1:0]                   access_size_t;
    typedef logic [7:0]                   pin_byte_t;
    typedef logic [`PERIPH_NUM_SLOTS-1:0] slot_sel_t;

    // Bit 4 picks a byte slot, bits 3..0 the slot number
    typedef logic [4:0]                   func_sel_t;

    // Size codes as issued by the core
    localparam access_size_t SIZE_BYTE = 2'b00;
    localparam access_size_t SIZE_HALF = 2'b01;
    localparam access_size_t SIZE_WORD = 2'b10;
    localparam access_size_t SIZE_IDLE = 2'b11;

    typedef struct packed {
        bus_addr_t    addr;
        bus_word_t    wdata;
        access_size_t write_size;
        access_size_t read_size;
    } periph_req_t;

    typedef struct packed {
        bus_word_t data;
        logic      ready;
        pin_byte_t pins;
    } user_rsp_t;

    typedef struct packed {
        pin_byte_t data;
        pin_byte_t pins;
    } simple_rsp_t;

endpackage

// File: logic/periph_top.sv
// Peripheral hub top; only slots 1, 4, 5 and byte slots 0, 1 are populated, other slots read 0
`include "periph_defines.svh"

module periph_top
    import periph_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,
    input  pin_byte_t   i_ui_in,
    output pin_byte_t   o_uo_out,
    input  periph_req_t i_req,
    output bus_word_t   o_data_out,
    output logic        o_data_ready,
    input  logic        i_data_read_complete,
    output logic [15:2] o_user_interrupts
);

    periph_req_t                            slot_req;
    slot_sel_t                              user_sel;
    slot_sel_t                              simple_sel;
    user_rsp_t                              bus_rsp;
    wire user_rsp_t   [`PERIPH_NUM_SLOTS-1:0] user_rsp;
    wire simple_rsp_t [`PERIPH_NUM_SLOTS-1:0] simple_rsp;
    wire pin_byte_t   [`PERIPH_NUM_SLOTS-1:0] user_pins;
    wire pin_byte_t   [`PERIPH_NUM_SLOTS-1:0] simple_pins;
    logic [1:0]                             word_irq;

    periph_decode i_decode (
        .i_req       (i_req),
        .i_user_rsp  (user_rsp),
        .i_simple_rsp(simple_rsp),
        .o_user_sel  (user_sel),
        .o_simple_sel(simple_sel),
        .o_rsp       (bus_rsp)
    );

    read_buffer i_read_buffer (
        .clk                 (clk),
        .rst_n               (rst_n),
        .i_req               (i_req),
        .i_rsp               (bus_rsp),
        .i_data_read_complete(i_data_read_complete),
        .o_slot_req          (slot_req),
        .o_data_out          (o_data_out),
        .o_data_ready        (o_data_ready)
    );

    gpio_ctrl i_gpio (
        .clk          (clk),
        .rst_n        (rst_n),
        .i_req        (slot_req),
        .i_sel        (user_sel[`PERIPH_GPIO_SLOT]),
        .i_ui_in      (i_ui_in),
        .i_user_pins  (user_pins),
        .i_simple_pins(simple_pins),
        .o_rsp        (user_rsp[`PERIPH_GPIO_SLOT]),
        .o_uo_out     (o_uo_out)
    );

    word_reg_periph i_word_a (
        .clk        (clk),
        .rst_n      (rst_n),
        .i_req      (slot_req),
        .i_sel      (user_sel[`PERIPH_WORD_SLOT_A]),
        .o_rsp      (user_rsp[`PERIPH_WORD_SLOT_A]),
        .o_interrupt(word_irq[0])
    );

    word_reg_periph i_word_b (
        .clk        (clk),
        .rst_n      (rst_n),
        .i_req      (slot_req),
        .i_sel      (user_sel[`PERIPH_WORD_SLOT_B]),
        .o_rsp      (user_rsp[`PERIPH_WORD_SLOT_B]),
        .o_interrupt(word_irq[1])
    );

    byte_latch_periph i_latch_0 (
        .clk  (clk),
        .rst_n(rst_n),
        .i_req(slot_req),
        .i_sel(simple_sel[0]),
        .o_rsp(simple_rsp[0])
    );

    byte_latch_periph i_latch_1 (
        .clk  (clk),
        .rst_n(rst_n),
        .i_req(slot_req),
        .i_sel(simple_sel[1]),
        .o_rsp(simple_rsp[1])
    );

    for (genvar s = 0; s < `PERIPH_NUM_SLOTS; s++) begin : g_slot
        // Empty slots read zero, stay ready and drive no pins
        if (s != `PERIPH_GPIO_SLOT && s != `PERIPH_WORD_SLOT_A && s != `PERIPH_WORD_SLOT_B)
        begin : g_user_empty
            assign user_rsp[s] = '{data: '0, ready: 1'b1, pins: '0};
        end
        if (s > 1) begin : g_simple_empty
            assign simple_rsp[s] = '{data: '0, pins: '0};
        end
        assign user_pins[s]   = user_rsp[s].pins;
        assign simple_pins[s] = simple_rsp[s].pins;
    end

    // Only the word registers raise interrupts 4 and 5
    assign o_user_interrupts = {10'h0, word_irq, 2'h0};

endmodule

// File: logic/read_buffer.sv
// Holds the first ready read result until read complete; write ready is combinational
`include "periph_defines.svh"

module read_buffer
    import periph_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,
    input  periph_req_t i_req,
    input  user_rsp_t   i_rsp,
    input  logic        i_data_read_complete,
    output periph_req_t o_slot_req,
    output bus_word_t   o_data_out,
    output logic        o_data_ready
);

    logic      read_req;
    logic      capture;
    logic      hold_q;
    logic      ready_q;
    bus_word_t data_q;

    assign read_req = i_req.read_size != SIZE_IDLE;
    assign capture  = !hold_q && i_rsp.ready && read_req;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            hold_q  <= 1'b0;
            ready_q <= 1'b0;
        end else begin
            if (i_data_read_complete) begin
                hold_q <= 1'b0;
            end
            // A new capture wins over a completing read
            if (capture) begin
                hold_q <= 1'b1;
            end
            ready_q <= read_req && i_rsp.ready;
        end
    end

    always_ff @(posedge clk) begin
        if (capture) begin
            data_q <= i_rsp.data;
        end
    end

    // Slots must not see a second read while the result is buffered
    always_comb begin
        o_slot_req = i_req;
        if (ready_q) begin
            o_slot_req.read_size = SIZE_IDLE;
        end
    end

    assign o_data_out   = data_q;
    assign o_data_ready = ready_q || (i_req.write_size != SIZE_IDLE);

endmodule

// File: logic/word_reg_periph.sv
// Word register with lane-merged writes; reads take one cycle, interrupt set at 0x0, cleared at 0x4
`include "periph_defines.svh"

module word_reg_periph
    import periph_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,
    input  periph_req_t i_req,
    input  logic        i_sel,
    output user_rsp_t   o_rsp,
    output logic        o_interrupt
);

    localparam logic [5:0] REG_OFS = 6'h00;
    localparam logic [5:0] IRQ_OFS = 6'h04;

    logic [5:0] ofs;
    logic       wr_en;
    logic       rd_en;
    bus_word_t  reg_q;
    bus_word_t  data_q;
    logic       ready_q;
    logic       irq_q;

    assign ofs   = i_req.addr[5:0];
    assign wr_en = i_sel && (i_req.write_size != SIZE_IDLE);
    assign rd_en = i_sel && (i_req.read_size != SIZE_IDLE);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            reg_q <= '0;
            irq_q <= 1'b0;
        end else if (wr_en) begin
            if (ofs == REG_OFS) begin
                unique case (i_req.write_size)
                    SIZE_BYTE: reg_q[7:0]  <= i_req.wdata[7:0];
                    SIZE_HALF: reg_q[15:0] <= i_req.wdata[15:0];
                    default:   reg_q       <= i_req.wdata;
                endcase
                irq_q <= 1'b1;
            end else if (ofs == IRQ_OFS) begin
                irq_q <= 1'b0;
            end
        end
    end

    // Ready follows a selected read by one cycle
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ready_q <= 1'b0;
        end else begin
            ready_q <= rd_en;
        end
    end

    always_ff @(posedge clk) begin
        if (rd_en) begin
            if (ofs == REG_OFS) begin
                data_q <= reg_q;
            end else if (ofs == IRQ_OFS) begin
                data_q <= bus_word_t'(irq_q);
            end else begin
                data_q <= '0;
            end
        end
    end

    assign o_rsp       = '{data: data_q, ready: ready_q, pins: reg_q[7:0]};
    assign o_interrupt = irq_q;

endmodule

// File: periph.f
+incdir+logic
logic/periph_pkg.sv
logic/periph_decode.sv
logic/read_buffer.sv
logic/gpio_ctrl.sv
logic/word_reg_periph.sv
logic/byte_latch_periph.sv
logic/periph_top.sv
testbench/periph_asserts.sv
testbench/periph_tb.sv

// File: testbench/periph_asserts.sv
// Bound into periph_top; the hold and ready inputs reach into the read buffer registers
module periph_asserts
    import periph_pkg::*;
(
    input logic        clk,
    input logic        rst_n,
    input slot_sel_t   i_user_sel,
    input slot_sel_t   i_simple_sel,
    input logic        i_hold,
    input logic        i_ready,
    input logic        i_data_read_complete,
    input bus_word_t   i_data_out,
    input logic [15:2] i_user_interrupts
);

    // Every address picks exactly one slot of either kind
    a_sel_onehot: assert property (@(posedge clk) disable iff (!rst_n)
        $onehot({i_user_sel, i_simple_sel}))
        else $error("Slot selects are not one-hot");

    // Buffered data only moves once the core has taken it
    a_hold_stable: assert property (@(posedge clk) disable iff (!rst_n)
        i_hold && !i_data_read_complete |=> $stable(i_data_out))
        else $error("Held read data changed before read complete");

    a_ready_reset: assert property (@(posedge clk)
        !rst_n |=> !i_ready)
        else $error("Registered ready is high after reset");

    a_irq_reset: assert property (@(posedge clk)
        !rst_n |=> i_user_interrupts == '0)
        else $error("Interrupts are high after reset");

endmodule

// File: testbench/periph_tb.sv
// Directed testbench for periph_top; needs timing support and assumes 64-byte user slot windows
`include "periph_defines.svh"

module periph_tb
    import periph_pkg::*;
();

    localparam int CLK_PERIOD   = 4;
    localparam int NUM_TESTS    = 6;
    localparam int READ_TIMEOUT = 20;
    localparam int GPIO_BASE    = `PERIPH_GPIO_SLOT * 64;

    localparam bus_addr_t GPIO_OUT = bus_addr_t'(GPIO_BASE + int'(`GPIO_OUT_OFS));
    localparam bus_addr_t GPIO_IN  = bus_addr_t'(GPIO_BASE + int'(`GPIO_IN_OFS));
    localparam bus_addr_t WORD_A   = bus_addr_t'(`PERIPH_WORD_SLOT_A * 64);
    localparam bus_addr_t WORD_B   = bus_addr_t'(`PERIPH_WORD_SLOT_B * 64);

    logic        clk;
    logic        rst_n;
    pin_byte_t   ui_in;
    pin_byte_t   uo_out;
    periph_req_t req;
    bus_word_t   data_out;
    logic        data_ready;
    logic        read_complete;
    logic [15:2] user_irq;

    int          errors;
    int          checks;
    logic [31:0] lcg_state;
    logic [7:0]  latch0_count;

    periph_top i_dut (
        .clk                 (clk),
        .rst_n               (rst_n),
        .i_ui_in             (ui_in),
        .o_uo_out            (uo_out),
        .i_req               (req),
        .o_data_out          (data_out),
        .o_data_ready        (data_ready),
        .i_data_read_complete(read_complete),
        .o_user_interrupts   (user_irq)
    );

    bind periph_top periph_asserts i_asserts (
        .clk                 (clk),
        .rst_n               (rst_n),
        .i_user_sel          (user_sel),
        .i_simple_sel        (simple_sel),
        .i_hold              (i_read_buffer.hold_q),
        .i_ready             (i_read_buffer.ready_q),
        .i_data_read_complete(i_data_read_complete),
        .i_data_out          (o_data_out),
        .i_user_interrupts   (o_user_interrupts)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state;
    endfunction

    function automatic bus_addr_t sel_addr(input int pin);
        return bus_addr_t'(GPIO_BASE + int'(`GPIO_SEL_BASE) + 4 * pin);
    endfunction

    // Byte slots sit above bit 10 in 16-byte windows
    function automatic bus_addr_t simple_addr(input int slot, input int ofs);
        return bus_addr_t'((1 << `PERIPH_SIMPLE_BIT) + 16 * slot + ofs);
    endfunction

    function automatic periph_req_t idle_req();
        return '{addr: '0, wdata: '0, write_size: SIZE_IDLE, read_size: SIZE_IDLE};
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] expected);
        checks++;
        if (got !== expected) begin
            errors++;
            $display("Mismatch %s: got 0x%0h, expected 0x%0h", name, got, expected);
        end
    endtask

    task automatic bus_write(input bus_addr_t addr, input bus_word_t data,
                             input access_size_t size);
        req = '{addr: addr, wdata: data, write_size: size, read_size: SIZE_IDLE};
        #1;
        check_value("o_data_ready", 32'(data_ready), 32'h1);
        @(posedge clk);
        #1;
        req = idle_req();
    endtask

    task automatic wait_ready();
        int cycles;
        cycles = 0;
        @(posedge clk);
        #1;
        while (!data_ready && cycles < READ_TIMEOUT) begin
            @(posedge clk);
            #1;
            cycles++;
        end
        if (!data_ready) begin
            errors++;
            $display("Read at 0x%0h saw no data ready within %0d cycles", req.addr, READ_TIMEOUT);
        end
    endtask

    task automatic finish_read();
        req = idle_req();
        read_complete = 1'b1;
        @(posedge clk);
        #1;
        read_complete = 1'b0;
    endtask

    task automatic read_check(input string name, input bus_addr_t addr,
                              input bus_word_t expected);
        req = '{addr: addr, wdata: '0, write_size: SIZE_IDLE, read_size: SIZE_WORD};
        wait_ready();
        check_value(name, data_out, expected);
        finish_read();
    endtask

    task automatic test_reset_values();
        for (int p = 0; p < 8; p++) begin
            read_check("func_sel", sel_addr(p),
                       (p < 2) ? `PERIPH_SERIAL_SLOT : `PERIPH_GPIO_SLOT);
        end
        check_value("o_uo_out", 32'(uo_out), 32'h0);
        check_value("o_user_interrupts", 32'(user_irq), 32'h0);
        read_check("gpio_out", GPIO_OUT, 32'h0);
    endtask

    task automatic test_gpio();
        bus_word_t v;
        pin_byte_t pins;
        repeat (3) begin
            v = lcg_next();
            bus_write(GPIO_OUT, v, SIZE_WORD);
            read_check("gpio_out", GPIO_OUT, {24'h0, v[7:0]});
            // Pins 0 and 1 still point at the empty serial slot
            check_value("o_uo_out", 32'(uo_out), {24'h0, v[7:2], 2'b00});
        end
        pins = pin_byte_t'(lcg_next());
        ui_in = pins;
        read_check("gpio_in", GPIO_IN, 32'(pins));
    endtask

    task automatic test_word_reg();
        bus_word_t w;
        bus_word_t exp_a;
        bus_word_t exp_b;
        exp_b = '0;
        w = lcg_next();
        bus_write(WORD_A, w, SIZE_WORD);
        exp_a = w;
        read_check("word_a", WORD_A, exp_a);
        check_value("o_user_interrupts[4]", 32'(user_irq[4]), 32'h1);
        check_value("o_user_interrupts[5]", 32'(user_irq[5]), 32'h0);
        w = lcg_next();
        bus_write(WORD_A, w, SIZE_HALF);
        exp_a[15:0] = w[15:0];
        read_check("word_a", WORD_A, exp_a);
        w = lcg_next();
        bus_write(WORD_A, w, SIZE_BYTE);
        exp_a[7:0] = w[7:0];
        read_check("word_a", WORD_A, exp_a);
        read_check("irq_a", WORD_A + 11'h4, 32'h1);
        w = lcg_next();
        bus_write(WORD_B, w, SIZE_BYTE);
        exp_b[7:0] = w[7:0];
        read_check("word_b", WORD_B, exp_b);
        check_value("o_user_interrupts[5]", 32'(user_irq[5]), 32'h1);
        bus_write(WORD_A + 11'h4, lcg_next(), SIZE_WORD);
        check_value("o_user_interrupts[4]", 32'(user_irq[4]), 32'h0);
        check_value("o_user_interrupts[5]", 32'(user_irq[5]), 32'h1);
        read_check("irq_a", WORD_A + 11'h4, 32'h0);
        read_check("irq_b", WORD_B + 11'h4, 32'h1);
        read_check("word_a", WORD_A, exp_a);
        bus_write(WORD_B + 11'h4, '0, SIZE_BYTE);
        check_value("o_user_interrupts", 32'(user_irq), 32'h0);
    endtask

    task automatic test_pin_routing();
        bus_word_t w;
        for (int n = 3; n < 8; n += 3) begin
            bus_write(sel_addr(n), `PERIPH_WORD_SLOT_A, SIZE_WORD);
            w = lcg_next();
            bus_write(WORD_A, w, SIZE_WORD);
            check_value("o_uo_out[n]", 32'(uo_out[n]), {31'h0, w[n]});
            bus_write(WORD_A, ~w, SIZE_WORD);
            check_value("o_uo_out[n]", 32'(uo_out[n]), {31'h0, ~w[n]});
            // Value 16 is byte slot 0
            bus_write(sel_addr(n), 32'd16, SIZE_WORD);
            w = lcg_next();
            bus_write(simple_addr(0, 0), w, SIZE_BYTE);
            check_value("o_uo_out[n]", 32'(uo_out[n]), {31'h0, w[n]});
            bus_write(simple_addr(0, 0), ~w, SIZE_BYTE);
            check_value("o_uo_out[n]", 32'(uo_out[n]), {31'h0, ~w[n]});
            // Drive the pin high so that an empty slot has to pull it low
            bus_write(simple_addr(0, 0), 32'hff, SIZE_BYTE);
            check_value("o_uo_out[n]", 32'(uo_out[n]), 32'h1);
            latch0_count = latch0_count + 8'd3;
            bus_write(sel_addr(n), 32'd3, SIZE_WORD);
            check_value("o_uo_out[n]", 32'(uo_out[n]), 32'h0);
            bus_write(sel_addr(n), 32'd16, SIZE_WORD);
            check_value("o_uo_out[n]", 32'(uo_out[n]), 32'h1);
            bus_write(sel_addr(n), 32'd23, SIZE_WORD);
            check_value("o_uo_out[n]", 32'(uo_out[n]), 32'h0);
            bus_write(sel_addr(n), `PERIPH_GPIO_SLOT, SIZE_WORD);
        end
        bus_write(WORD_A + 11'h4, '0, SIZE_WORD);
    endtask

    task automatic test_latch_and_empty();
        bus_word_t w;
        read_check("latch0_count", simple_addr(0, 1), 32'(latch0_count));
        w = lcg_next();
        bus_write(simple_addr(0, 0), w, SIZE_HALF);
        w = lcg_next();
        bus_write(simple_addr(0, 0), w, SIZE_WORD);
        latch0_count = latch0_count + 8'd2;
        read_check("latch0_data", simple_addr(0, 0), {24'h0, w[7:0]});
        read_check("latch0_count", simple_addr(0, 1), 32'(latch0_count));
        w = lcg_next();
        bus_write(simple_addr(1, 0), w, SIZE_BYTE);
        read_check("latch1_data", simple_addr(1, 0), {24'h0, w[7:0]});
        read_check("latch1_count", simple_addr(1, 1), 32'h1);
        read_check("latch1_other", simple_addr(1, 5), 32'h0);
        read_check("user_slot_0", bus_addr_t'(0), 32'h0);
        read_check("user_slot_3", bus_addr_t'(3 * 64), 32'h0);
        read_check("user_slot_15", bus_addr_t'(15 * 64 + 8), 32'h0);
        read_check("byte_slot_2", simple_addr(2, 0), 32'h0);
        read_check("byte_slot_15", simple_addr(15, 1), 32'h0);
    endtask

    task automatic test_read_hold();
        pin_byte_t first;
        pin_byte_t second;
        first = pin_byte_t'(lcg_next());
        second = ~first;
        ui_in = first;
        req = '{addr: GPIO_IN, wdata: '0, write_size: SIZE_IDLE, read_size: SIZE_WORD};
        wait_ready();
        check_value("o_data_out", data_out, 32'(first));
        // The pins move on while the first result is still held
        ui_in = second;
        repeat (3) begin
            @(posedge clk);
            #1;
            check_value("o_data_ready", 32'(data_ready), 32'h1);
            check_value("o_data_out", data_out, 32'(first));
        end
        finish_read();
        read_check("gpio_in", GPIO_IN, 32'(second));
    endtask

    initial begin
        clk = 1'b0;
        rst_n = 1'b0;
        ui_in = '0;
        req = idle_req();
        read_complete = 1'b0;
        errors = 0;
        checks = 0;
        lcg_state = 32'd1;
        latch0_count = '0;
        repeat (2) @(posedge clk);
        #1;
        rst_n = 1'b1;
        test_reset_values();
        test_gpio();
        test_word_reg();
        test_pin_routing();
        test_latch_and_empty();
        test_read_hold();
        $display("Checks run: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

    initial begin
        #(NUM_TESTS * 200 * CLK_PERIOD);
        $display("Watchdog timeout: the tests did not finish within %0d cycles", NUM_TESTS * 200);
        $display("CHECKS FAILED");
        $finish;
    end

endmodule
